// File: Makefile
# Verilator build, run, lint and clean for the instruction decoder.

VERILATOR ?= verilator
TOP       ?= arm_decode_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result.
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/arm_alu_fields.sv
module arm_alu_fields import arm_decode_pkg::*; (
        input  logic                   i_clk,
        input  logic                   i_rst_n,
        input  logic                   i_ld_en,
        input  instr_class_t           i_cls,
        input  logic [INSTR_W-1:0]     i_instruction,
        output logic [ALU_OP_W-1:0]    o_alu_operation,
        output logic [OPND_W-1:0]      o_alu_source,
        output logic [REG_IDX_W-1:0]   o_destination_index,
        output logic                   o_flag_update
);

instr_word_u           w;
logic [ALU_OP_W-1:0]   op_nxt;
logic [OPND_W-1:0]     src_nxt;
logic [REG_IDX_W-1:0]  dest_nxt;
logic                  flag_nxt;

assign w = i_instruction;

always_comb
begin
        // Entry default. LR = PC - 4.
        op_nxt   = SUB;
        src_nxt  = {INDEX_EN, 27'd0, ARCH_PC};
        dest_nxt = ARCH_LR;
        flag_nxt = 1'b0;
        case (i_cls)
        CLS_DP:
        begin
                op_nxt   = w.dp.opcode;
                src_nxt  = {INDEX_EN, 28'd0, w.dp.rn};
                flag_nxt = w.dp.s;
                // Compares write no register.
                if (w.dp.opcode inside {TST, TEQ, CMP, CMN})
                        dest_nxt = RAZ_REGISTER;
                else
                        dest_nxt = {1'b0, w.dp.rd};
        end
        CLS_LS:
        begin
                op_nxt  = w.ls.up ? ADD : SUB;
                src_nxt = {INDEX_EN, 28'd0, w.ls.rn};   // Base pointer.
                // Base updates on writeback or post-index.
                dest_nxt = (w.ls.wb || !w.ls.pre) ? {1'b0, w.ls.rn} : RAZ_REGISTER;
        end
        CLS_BRANCH:
        begin
                op_nxt   = ADD;                 // PC = PC + offset.
                dest_nxt = ARCH_PC;
        end
        default:
        begin
                op_nxt = SUB;
        end
        endcase
end

// ==============================
// Output registers
// ==============================
always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
        begin
                o_destination_index <= RAZ_REGISTER;
                o_flag_update       <= 1'b0;
        end
        else if (i_ld_en)
        begin
                o_destination_index <= dest_nxt;
                o_flag_update       <= flag_nxt;
        end
end

always_ff @(posedge i_clk)
begin
        if (i_ld_en)
        begin
                o_alu_operation <= op_nxt;
                o_alu_source    <= src_nxt;
        end
end

endmodule

// File: rtl/arm_decode.sv
module arm_decode import arm_decode_pkg::*; (
        input  logic                   i_clk,
        input  logic                   i_rst_n,
        input  logic                   i_req,
        input  logic [INSTR_W-1:0]     i_instruction,
        input  logic                   i_irq,
        input  logic                   i_fiq,
        input  logic                   i_abt,
        output logic                   o_ack,
        output logic [3:0]             o_condition_code,
        output logic [REG_IDX_W-1:0]   o_destination_index,
        output logic [ALU_OP_W-1:0]    o_alu_operation,
        output logic [OPND_W-1:0]      o_alu_source,
        output logic [OPND_W-1:0]      o_shift_source,
        output logic [SHIFT_OP_W-1:0]  o_shift_operation,
        output logic [OPND_W-1:0]      o_shift_length,
        output logic                   o_flag_update,
        output logic [REG_IDX_W-1:0]   o_mem_srcdest_index,
        output logic                   o_mem_load,
        output logic                   o_mem_store,
        output logic                   o_mem_pre_index,
        output logic                   o_mem_unsigned_byte_enable,
        output logic                   o_mem_translate,
        output logic                   o_und
);

logic         ld_en;    // Capture strobe.
instr_class_t cls;      // Decoded class.

arm_decode_ctrl u_ctrl (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_req            (i_req),
        .i_instruction    (i_instruction),
        .i_irq            (i_irq),
        .i_fiq            (i_fiq),
        .i_abt            (i_abt),
        .o_ack            (o_ack),
        .o_ld_en          (ld_en),
        .o_cls            (cls),
        .o_condition_code (o_condition_code),
        .o_und            (o_und)
);

arm_shifter_operand u_shifter (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_ld_en           (ld_en),
        .i_cls             (cls),
        .i_instruction     (i_instruction),
        .o_shift_source    (o_shift_source),
        .o_shift_length    (o_shift_length),
        .o_shift_operation (o_shift_operation)
);

arm_alu_fields u_alu (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_ld_en             (ld_en),
        .i_cls               (cls),
        .i_instruction       (i_instruction),
        .o_alu_operation     (o_alu_operation),
        .o_alu_source        (o_alu_source),
        .o_destination_index (o_destination_index),
        .o_flag_update       (o_flag_update)
);

arm_mem_fields u_mem (
        .i_clk                      (i_clk),
        .i_rst_n                    (i_rst_n),
        .i_ld_en                    (ld_en),
        .i_cls                      (cls),
        .i_instruction              (i_instruction),
        .o_mem_srcdest_index        (o_mem_srcdest_index),
        .o_mem_load                 (o_mem_load),
        .o_mem_store                (o_mem_store),
        .o_mem_pre_index            (o_mem_pre_index),
        .o_mem_unsigned_byte_enable (o_mem_unsigned_byte_enable),
        .o_mem_translate            (o_mem_translate)
);

endmodule

// File: rtl/arm_decode_ctrl.sv
module arm_decode_ctrl import arm_decode_pkg::*; (
        input  logic                  i_clk,
        input  logic                  i_rst_n,
        input  logic                  i_req,
        input  logic [INSTR_W-1:0]    i_instruction,
        input  logic                  i_irq,
        input  logic                  i_fiq,
        input  logic                  i_abt,
        output logic                  o_ack,
        output logic                  o_ld_en,
        output instr_class_t          o_cls,
        output logic [3:0]            o_condition_code,
        output logic                  o_und
);

logic exc_pend;         // Any entry request.

assign exc_pend = i_irq || i_fiq || i_abt;

// Capture strobe while ack is low.
assign o_ld_en = i_req && !o_ack;

// ==============================
// Handshake
// ==============================
// Ack itself is the state. Low is idle and high is holding.
always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
                o_ack <= 1'b0;
        else if (o_ld_en)
                o_ack <= 1'b1;          // Captured.
        else if (!i_req)
                o_ack <= 1'b0;          // Released.
end

// ==============================
// Classification
// ==============================
always_comb
begin
        if (exc_pend)
                o_cls = CLS_EXC;
        else if (i_instruction[27:24] == 4'b1111)
                o_cls = CLS_SWI;
        else if (i_instruction[27:25] == 3'b101)
                o_cls = CLS_BRANCH;
        else if (i_instruction[27:26] == 2'b01)
        begin
                // Register offset with bit 4 set is undefined.
                o_cls = (i_instruction[25] && i_instruction[4]) ? CLS_UND : CLS_LS;
        end
        else if (i_instruction[27:26] == 2'b00)
        begin
                // Multiply and halfword space are dropped.
                if (!i_instruction[25] && i_instruction[7] && i_instruction[4])
                        o_cls = CLS_UND;
                else
                        o_cls = CLS_DP;
        end
        else
                o_cls = CLS_UND;
end

// Condition and undefined flag.
always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
        begin
                o_condition_code <= COND_NV;    // Nothing valid yet.
                o_und            <= 1'b0;
        end
        else if (o_ld_en)
        begin
                if (o_cls == CLS_EXC || o_cls == CLS_UND)
                        o_condition_code <= COND_AL;    // Entry always runs.
                else
                        o_condition_code <= i_instruction[31:28];
                o_und <= (o_cls == CLS_UND);
        end
end

endmodule

// File: rtl/arm_decode_pkg.sv
package arm_decode_pkg;

// ==============================
// Widths
// ==============================
localparam int INSTR_W    = 32;                 // Instruction word.
localparam int REG_IDX_W  = 5;                  // 16 registers and a discard slot.
localparam int OPND_W     = 33;                 // Bit 32 is the index flag.
localparam int ALU_OP_W   = 4;
localparam int SHIFT_OP_W = 3;

// Register indices.
localparam logic [REG_IDX_W-1:0] ARCH_LR      = 5'd14;
localparam logic [REG_IDX_W-1:0] ARCH_PC      = 5'd15;
localparam logic [REG_IDX_W-1:0] RAZ_REGISTER = 5'd16;    // Write goes nowhere.

// Operand flag bit.
localparam logic IMMED_EN = 1'b0;
localparam logic INDEX_EN = 1'b1;

// Condition codes.
localparam logic [3:0] COND_AL = 4'd14;
localparam logic [3:0] COND_NV = 4'd15;

// ==============================
// ALU opcodes
// ==============================
localparam logic [ALU_OP_W-1:0] AND = 4'd0;
localparam logic [ALU_OP_W-1:0] EOR = 4'd1;
localparam logic [ALU_OP_W-1:0] SUB = 4'd2;
localparam logic [ALU_OP_W-1:0] RSB = 4'd3;
localparam logic [ALU_OP_W-1:0] ADD = 4'd4;
localparam logic [ALU_OP_W-1:0] ADC = 4'd5;
localparam logic [ALU_OP_W-1:0] SBC = 4'd6;
localparam logic [ALU_OP_W-1:0] RSC = 4'd7;
localparam logic [ALU_OP_W-1:0] TST = 4'd8;     // Compare group.
localparam logic [ALU_OP_W-1:0] TEQ = 4'd9;
localparam logic [ALU_OP_W-1:0] CMP = 4'd10;
localparam logic [ALU_OP_W-1:0] CMN = 4'd11;
localparam logic [ALU_OP_W-1:0] ORR = 4'd12;
localparam logic [ALU_OP_W-1:0] MOV = 4'd13;
localparam logic [ALU_OP_W-1:0] BIC = 4'd14;
localparam logic [ALU_OP_W-1:0] MVN = 4'd15;

// Shift codes. Low four match the instruction's shift bits.
localparam logic [SHIFT_OP_W-1:0] LSL   = 3'd0;
localparam logic [SHIFT_OP_W-1:0] LSR   = 3'd1;
localparam logic [SHIFT_OP_W-1:0] ASR   = 3'd2;
localparam logic [SHIFT_OP_W-1:0] ROR   = 3'd3;
localparam logic [SHIFT_OP_W-1:0] RORI  = 3'd4;   // Immediate rotate.
localparam logic [SHIFT_OP_W-1:0] RRC   = 3'd5;   // Through carry.
localparam logic [SHIFT_OP_W-1:0] ROR_1 = 3'd6;   // Non-zero register rotate.

// Instruction classes.
typedef logic [2:0] instr_class_t;
localparam instr_class_t CLS_DP     = 3'd0;
localparam instr_class_t CLS_LS     = 3'd1;
localparam instr_class_t CLS_BRANCH = 3'd2;
localparam instr_class_t CLS_SWI    = 3'd3;
localparam instr_class_t CLS_UND    = 3'd4;
localparam instr_class_t CLS_EXC    = 3'd5;

// One word, two field layouts.
typedef union packed {
        struct packed {
                logic [3:0]  cond;
                logic [1:0]  cls_bits;
                logic        imm;               // Rotated immediate form.
                logic [3:0]  opcode;
                logic        s;                 // Flag update.
                logic [3:0]  rn;
                logic [3:0]  rd;
                logic [11:0] operand;
        } dp;
        struct packed {
                logic [3:0]  cond;
                logic [1:0]  cls_bits;
                logic        reg_off;           // Register offset.
                logic        pre;
                logic        up;
                logic        byte_sel;
                logic        wb;
                logic        load;
                logic [3:0]  rn;                // Base.
                logic [3:0]  rd;                // Data.
                logic [11:0] offset;
        } ls;
} instr_word_u;

endpackage

// File: rtl/arm_mem_fields.sv
module arm_mem_fields import arm_decode_pkg::*; (
        input  logic                   i_clk,
        input  logic                   i_rst_n,
        input  logic                   i_ld_en,
        input  instr_class_t           i_cls,
        input  logic [INSTR_W-1:0]     i_instruction,
        output logic [REG_IDX_W-1:0]   o_mem_srcdest_index,
        output logic                   o_mem_load,
        output logic                   o_mem_store,
        output logic                   o_mem_pre_index,
        output logic                   o_mem_unsigned_byte_enable,
        output logic                   o_mem_translate
);

instr_word_u w;
logic        is_ls;

assign w     = i_instruction;
assign is_ls = (i_cls == CLS_LS);

always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
        begin
                o_mem_srcdest_index        <= RAZ_REGISTER;
                o_mem_load                 <= 1'b0;
                o_mem_store                <= 1'b0;
                o_mem_pre_index            <= 1'b0;
                o_mem_unsigned_byte_enable <= 1'b0;
                o_mem_translate            <= 1'b0;
        end
        else if (i_ld_en)
        begin
                o_mem_srcdest_index        <= is_ls ? {1'b0, w.ls.rd} : RAZ_REGISTER;
                o_mem_load                 <= is_ls && w.ls.load;
                o_mem_store                <= is_ls && !w.ls.load;
                o_mem_pre_index            <= is_ls && w.ls.pre;
                o_mem_unsigned_byte_enable <= is_ls && w.ls.byte_sel;
                // Post-index with W forces user view.
                o_mem_translate            <= is_ls && !w.ls.pre && w.ls.wb;
        end
end

endmodule

// File: rtl/arm_shifter_operand.sv
module arm_shifter_operand import arm_decode_pkg::*; (
        input  logic                   i_clk,
        input  logic                   i_rst_n,
        input  logic                   i_ld_en,
        input  instr_class_t           i_cls,
        input  logic [INSTR_W-1:0]     i_instruction,
        output logic [OPND_W-1:0]      o_shift_source,
        output logic [OPND_W-1:0]      o_shift_length,
        output logic [SHIFT_OP_W-1:0]  o_shift_operation
);

logic [OPND_W-1:0]     iss_len;
logic [SHIFT_OP_W-1:0] iss_op;
logic [OPND_W-1:0]     src_nxt;
logic [OPND_W-1:0]     len_nxt;
logic [SHIFT_OP_W-1:0] op_nxt;

// ==============================
// Instruction-specified shift
// ==============================
// Shared by DP and LS register offset.
always_comb
begin
        iss_len = {IMMED_EN, 27'd0, i_instruction[11:7]};
        case ({1'b0, i_instruction[6:5]})
        LSR, ASR:
        begin
                iss_op = {1'b0, i_instruction[6:5]};
                if (i_instruction[11:7] == 5'd0)
                        iss_len = {IMMED_EN, 32'd32};   // #0 means #32.
        end
        ROR:
                iss_op = (i_instruction[11:7] == 5'd0) ? RRC : ROR_1;
        default:
                iss_op = LSL;
        endcase
end

// Per class operand.
always_comb
begin
        src_nxt = {IMMED_EN, 32'd4};            // PC - 4 for entries.
        len_nxt = {IMMED_EN, 32'd0};
        op_nxt  = LSL;
        case (i_cls)
        CLS_DP:
        begin
                if (i_instruction[25])
                begin
                        src_nxt = {IMMED_EN, 24'd0, i_instruction[7:0]};
                        if (i_instruction[11:8] != 4'd0)
                        begin
                                len_nxt = {IMMED_EN, 27'd0, i_instruction[11:8], 1'b0};
                                op_nxt  = RORI;
                        end
                end
                else if (i_instruction[4])
                begin
                        // Register-specified shift. Rs gives length.
                        src_nxt = {INDEX_EN, 28'd0, i_instruction[3:0]};
                        len_nxt = {INDEX_EN, 28'd0, i_instruction[11:8]};
                        op_nxt  = {1'b0, i_instruction[6:5]};
                end
                else
                begin
                        src_nxt = {INDEX_EN, 28'd0, i_instruction[3:0]};
                        len_nxt = iss_len;
                        op_nxt  = iss_op;
                end
        end
        CLS_LS:
        begin
                if (i_instruction[25])
                begin
                        src_nxt = {INDEX_EN, 28'd0, i_instruction[3:0]};
                        len_nxt = iss_len;
                        op_nxt  = iss_op;
                end
                else
                        src_nxt = {IMMED_EN, 20'd0, i_instruction[11:0]};   // 12-bit offset.
        end
        CLS_BRANCH:
        begin
                src_nxt = {IMMED_EN, {8{i_instruction[23]}}, i_instruction[23:0]};
                len_nxt = {IMMED_EN, 32'd2};    // Word offset.
        end
        default:
        begin
                src_nxt = {IMMED_EN, 32'd4};
        end
        endcase
end

always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
        begin
                o_shift_source    <= {IMMED_EN, 32'd0};
                o_shift_length    <= {IMMED_EN, 32'd0};
                o_shift_operation <= LSL;
        end
        else if (i_ld_en)
        begin
                o_shift_source    <= src_nxt;
                o_shift_length    <= len_nxt;
                o_shift_operation <= op_nxt;
        end
end

endmodule

// File: src.f
rtl/arm_decode_pkg.sv
rtl/arm_decode_ctrl.sv
rtl/arm_shifter_operand.sv
rtl/arm_alu_fields.sv
rtl/arm_mem_fields.sv
rtl/arm_decode.sv
verification/arm_decode_assertions.sv
verification/arm_decode_tb.sv

// File: verification/arm_decode_assertions.sv
module arm_decode_assertions import arm_decode_pkg::*; (
        input logic                  i_clk,
        input logic                  i_rst_n,
        input logic                  i_req,
        input logic                  i_ack,
        input logic [3:0]            i_condition_code,
        input logic [REG_IDX_W-1:0]  i_destination_index,
        input logic [ALU_OP_W-1:0]   i_alu_operation,
        input logic [OPND_W-1:0]     i_alu_source,
        input logic [OPND_W-1:0]     i_shift_source,
        input logic [OPND_W-1:0]     i_shift_length,
        input logic [SHIFT_OP_W-1:0] i_shift_operation,
        input logic [REG_IDX_W-1:0]  i_mem_srcdest_index,
        input logic                  i_und
);

// ==============================
// Handshake
// ==============================
ack_rise_with_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_ack) |-> $past(i_req))
        else $error("o_ack rose without i_req");

ack_fall_without_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(i_ack) |-> !$past(i_req))
        else $error("o_ack fell while i_req was high");

// Outputs frozen during ack.
outputs_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_ack && $past(i_ack)) |-> $stable({i_condition_code, i_destination_index,
                i_alu_operation, i_alu_source, i_shift_source, i_shift_length,
                i_shift_operation, i_mem_srcdest_index, i_und}))
        else $error("decoded outputs changed while o_ack was high");

// ==============================
// Output legality
// ==============================
rori_nonzero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_shift_operation == RORI) |-> (i_shift_length[31:0] != 32'd0))
        else $error("RORI with zero length");

und_to_lr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_und |-> (i_destination_index == ARCH_LR))
        else $error("undefined entry without LR destination");

endmodule

bind arm_decode arm_decode_assertions u_assertions (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_req               (i_req),
        .i_ack               (o_ack),
        .i_condition_code    (o_condition_code),
        .i_destination_index (o_destination_index),
        .i_alu_operation     (o_alu_operation),
        .i_alu_source        (o_alu_source),
        .i_shift_source      (o_shift_source),
        .i_shift_length      (o_shift_length),
        .i_shift_operation   (o_shift_operation),
        .i_mem_srcdest_index (o_mem_srcdest_index),
        .i_und               (o_und)
);

// File: verification/arm_decode_tb.sv
module arm_decode_tb import arm_decode_pkg::*; ();

logic                  clk;
logic                  rst_n;
logic                  req;
logic [INSTR_W-1:0]    instruction;
logic                  irq;
logic                  fiq;
logic                  abt;
logic                  ack;
logic [3:0]            condition_code;
logic [REG_IDX_W-1:0]  destination_index;
logic [ALU_OP_W-1:0]   alu_operation;
logic [OPND_W-1:0]     alu_source;
logic [OPND_W-1:0]     shift_source;
logic [SHIFT_OP_W-1:0] shift_operation;
logic [OPND_W-1:0]     shift_length;
logic                  flag_update;
logic [REG_IDX_W-1:0]  mem_srcdest_index;
logic                  mem_load;
logic                  mem_store;
logic                  mem_pre_index;
logic                  mem_byte;
logic                  mem_translate;
logic                  und;
int                    entry_idx;       // Entry under test.

// ==============================
// Stimulus table
// ==============================
logic [INSTR_W-1:0]    t_instr[$];
logic [2:0]            t_exc[$];        // {irq, fiq, abt}.
int                    t_hold[$];       // Extra cycles with req held.
logic [3:0]            t_cond[$];
logic [REG_IDX_W-1:0]  t_dest[$];
logic [ALU_OP_W-1:0]   t_alu_op[$];
logic [OPND_W-1:0]     t_alu_src[$];
logic                  t_flag[$];
logic [OPND_W-1:0]     t_sh_src[$];
logic [SHIFT_OP_W-1:0] t_sh_op[$];
logic [OPND_W-1:0]     t_sh_len[$];
logic [REG_IDX_W-1:0]  t_mem_idx[$];
logic [4:0]            t_mem_ctl[$];    // {load, store, pre, byte, translate}.
logic                  t_und[$];

arm_decode u_arm_decode (
        .i_clk                      (clk),
        .i_rst_n                    (rst_n),
        .i_req                      (req),
        .i_instruction              (instruction),
        .i_irq                      (irq),
        .i_fiq                      (fiq),
        .i_abt                      (abt),
        .o_ack                      (ack),
        .o_condition_code           (condition_code),
        .o_destination_index        (destination_index),
        .o_alu_operation            (alu_operation),
        .o_alu_source               (alu_source),
        .o_shift_source             (shift_source),
        .o_shift_operation          (shift_operation),
        .o_shift_length             (shift_length),
        .o_flag_update              (flag_update),
        .o_mem_srcdest_index        (mem_srcdest_index),
        .o_mem_load                 (mem_load),
        .o_mem_store                (mem_store),
        .o_mem_pre_index            (mem_pre_index),
        .o_mem_unsigned_byte_enable (mem_byte),
        .o_mem_translate            (mem_translate),
        .o_und                      (und)
);

initial
begin
        clk = 1'b0;
        forever
                #4 clk = ~clk;          // Period 8.
end

task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
endtask

task automatic check_value(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
        if (actual !== expected)
                abort_run($sformatf("error at %0t: entry %0d %s expected %0h got %0h",
                                    $time, entry_idx, name, expected, actual));
endtask

// Polls o_ack after each edge. Returns the edge count.
task automatic wait_ack(input logic level, output int cycles);
        cycles = 0;
        while (ack !== level)
        begin
                @(posedge clk);
                #2;
                cycles++;
                if (cycles >= 20)
                        abort_run($sformatf("o_ack never reached %0b within 20 cycles in entry %0d",
                                            level, entry_idx));
        end
endtask

function automatic logic [OPND_W-1:0] reg_opnd(input logic [31:0] v);
        return {INDEX_EN, v};
endfunction

function automatic logic [OPND_W-1:0] imm_opnd(input logic [31:0] v);
        return {IMMED_EN, v};
endfunction

task automatic add_entry(input logic [31:0] instr, input logic [2:0] exc, input int hold,
                         input logic [3:0] cond, input logic [4:0] dest,
                         input logic [3:0] alu_op, input logic [32:0] alu_src,
                         input logic flag, input logic [32:0] sh_src,
                         input logic [2:0] sh_op, input logic [32:0] sh_len,
                         input logic [4:0] mem_idx, input logic [4:0] mem_ctl,
                         input logic und_exp);
        t_instr.push_back(instr);
        t_exc.push_back(exc);
        t_hold.push_back(hold);
        t_cond.push_back(cond);
        t_dest.push_back(dest);
        t_alu_op.push_back(alu_op);
        t_alu_src.push_back(alu_src);
        t_flag.push_back(flag);
        t_sh_src.push_back(sh_src);
        t_sh_op.push_back(sh_op);
        t_sh_len.push_back(sh_len);
        t_mem_idx.push_back(mem_idx);
        t_mem_ctl.push_back(mem_ctl);
        t_und.push_back(und_exp);
endtask

task automatic build_table();
        // MOVSEQ r3, #0x55. Zero rotate.
        add_entry(32'h03B03055, 3'b000, 0, 4'h0, 5'd3, MOV, reg_opnd(0), 1'b1,
                  imm_opnd(32'h55), LSL, imm_opnd(0), RAZ_REGISTER, 5'b00000, 1'b0);
        // ADD r1, r2, #0x3F ROR 8. Held 10 cycles.
        add_entry(32'hE282143F, 3'b000, 10, 4'hE, 5'd1, ADD, reg_opnd(2), 1'b0,
                  imm_opnd(32'h3F), RORI, imm_opnd(8), RAZ_REGISTER, 5'b00000, 1'b0);
        add_entry(32'hE1A04025, 3'b000, 0, 4'hE, 5'd4, MOV, reg_opnd(0), 1'b0,
                  reg_opnd(5), LSR, imm_opnd(32), RAZ_REGISTER, 5'b00000, 1'b0);  // LSR #0.
        add_entry(32'h11B06067, 3'b000, 0, 4'h1, 5'd6, MOV, reg_opnd(0), 1'b1,
                  reg_opnd(7), RRC, imm_opnd(0), RAZ_REGISTER, 5'b00000, 1'b0);   // ROR #0.
        add_entry(32'hE02981EA, 3'b000, 0, 4'hE, 5'd8, EOR, reg_opnd(9), 1'b0,
                  reg_opnd(10), ROR_1, imm_opnd(3), RAZ_REGISTER, 5'b00000, 1'b0);
        // SUB r2, r3, r4, ASR r5.
        add_entry(32'hE0432554, 3'b000, 0, 4'hE, 5'd2, SUB, reg_opnd(3), 1'b0,
                  reg_opnd(4), ASR, reg_opnd(5), RAZ_REGISTER, 5'b00000, 1'b0);
        add_entry(32'hE3510001, 3'b000, 0, 4'hE, RAZ_REGISTER, CMP, reg_opnd(1), 1'b1,
                  imm_opnd(1), LSL, imm_opnd(0), RAZ_REGISTER, 5'b00000, 1'b0);   // CMP r1, #1.
        // LDR r0, [r1, #4]! then STRB r2, [r3, #-8].
        add_entry(32'hE5B10004, 3'b000, 0, 4'hE, 5'd1, ADD, reg_opnd(1), 1'b0,
                  imm_opnd(4), LSL, imm_opnd(0), 5'd0, 5'b10100, 1'b0);
        add_entry(32'hE5432008, 3'b000, 0, 4'hE, RAZ_REGISTER, SUB, reg_opnd(3), 1'b0,
                  imm_opnd(8), LSL, imm_opnd(0), 5'd2, 5'b01110, 1'b0);
        // LDRT r5, [r6], r7, LSL #2.
        add_entry(32'hE6B65107, 3'b000, 0, 4'hE, 5'd6, ADD, reg_opnd(6), 1'b0,
                  reg_opnd(7), LSL, imm_opnd(2), 5'd5, 5'b10001, 1'b0);
        add_entry(32'hEAFFFFFE, 3'b000, 0, 4'hE, ARCH_PC, ADD, reg_opnd(15), 1'b0,
                  imm_opnd(32'hFFFFFFFE), LSL, imm_opnd(2), RAZ_REGISTER, 5'b00000, 1'b0);
        add_entry(32'hCB000010, 3'b000, 0, 4'hC, ARCH_PC, ADD, reg_opnd(15), 1'b0,
                  imm_opnd(32'h10), LSL, imm_opnd(2), RAZ_REGISTER, 5'b00000, 1'b0);
        // Entry paths. SWI, MUL pattern, irq, abt, fiq.
        add_entry(32'h1F000012, 3'b000, 0, 4'h1, ARCH_LR, SUB, reg_opnd(15), 1'b0,
                  imm_opnd(4), LSL, imm_opnd(0), RAZ_REGISTER, 5'b00000, 1'b0);
        add_entry(32'h00000291, 3'b000, 0, COND_AL, ARCH_LR, SUB, reg_opnd(15), 1'b0,
                  imm_opnd(4), LSL, imm_opnd(0), RAZ_REGISTER, 5'b00000, 1'b1);
        add_entry(32'hE5B10004, 3'b100, 0, COND_AL, ARCH_LR, SUB, reg_opnd(15), 1'b0,
                  imm_opnd(4), LSL, imm_opnd(0), RAZ_REGISTER, 5'b00000, 1'b0);
        add_entry(32'h03B03055, 3'b001, 0, COND_AL, ARCH_LR, SUB, reg_opnd(15), 1'b0,
                  imm_opnd(4), LSL, imm_opnd(0), RAZ_REGISTER, 5'b00000, 1'b0);
        add_entry(32'hEAFFFFFE, 3'b010, 0, COND_AL, ARCH_LR, SUB, reg_opnd(15), 1'b0,
                  imm_opnd(4), LSL, imm_opnd(0), RAZ_REGISTER, 5'b00000, 1'b0);
endtask

task automatic check_outputs(input int i);
        check_value("o_condition_code", 64'(condition_code), 64'(t_cond[i]));
        check_value("o_destination_index", 64'(destination_index), 64'(t_dest[i]));
        check_value("o_alu_operation", 64'(alu_operation), 64'(t_alu_op[i]));
        check_value("o_alu_source", 64'(alu_source), 64'(t_alu_src[i]));
        check_value("o_flag_update", 64'(flag_update), 64'(t_flag[i]));
        check_value("o_shift_source", 64'(shift_source), 64'(t_sh_src[i]));
        check_value("o_shift_operation", 64'(shift_operation), 64'(t_sh_op[i]));
        check_value("o_shift_length", 64'(shift_length), 64'(t_sh_len[i]));
        check_value("o_mem_srcdest_index", 64'(mem_srcdest_index), 64'(t_mem_idx[i]));
        check_value("o_mem_load", 64'(mem_load), 64'(t_mem_ctl[i][4]));
        check_value("o_mem_store", 64'(mem_store), 64'(t_mem_ctl[i][3]));
        check_value("o_mem_pre_index", 64'(mem_pre_index), 64'(t_mem_ctl[i][2]));
        check_value("o_mem_unsigned_byte_enable", 64'(mem_byte), 64'(t_mem_ctl[i][1]));
        check_value("o_mem_translate", 64'(mem_translate), 64'(t_mem_ctl[i][0]));
        check_value("o_und", 64'(und), 64'(t_und[i]));
endtask

// One four-phase transfer.
task automatic run_entry(input int i);
        int cycles;
        int k;
        entry_idx = i;
        @(posedge clk);
        #1;
        check_value("o_ack", 64'(ack), 64'(1'b0));    // Idle before the request.
        instruction     = t_instr[i];
        {irq, fiq, abt} = t_exc[i];
        req             = 1'b1;
        wait_ack(1'b1, cycles);
        check_value("capture latency", 64'(cycles), 64'(1));
        check_outputs(i);
        for (k = 0; k < t_hold[i]; k++)
        begin
                @(posedge clk);
                #2;
                check_value("o_ack", 64'(ack), 64'(1'b1));    // Back-pressure.
                check_outputs(i);
        end
        @(posedge clk);
        #1;
        req = 1'b0;
        wait_ack(1'b0, cycles);
        check_value("release latency", 64'(cycles), 64'(1));
endtask

// ==============================
// Main sequence
// ==============================
initial
begin
        rst_n       = 1'b0;
        req         = 1'b0;
        instruction = '0;
        irq         = 1'b0;
        fiq         = 1'b0;
        abt         = 1'b0;
        entry_idx   = -1;               // Reset checks.
        build_table();
        repeat (4) @(posedge clk);
        #1;
        check_value("o_ack", 64'(ack), 64'(1'b0));
        check_value("o_und", 64'(und), 64'(1'b0));
        check_value("o_mem_load", 64'(mem_load), 64'(1'b0));
        check_value("o_mem_store", 64'(mem_store), 64'(1'b0));
        check_value("o_flag_update", 64'(flag_update), 64'(1'b0));
        check_value("o_condition_code", 64'(condition_code), 64'(COND_NV));
        check_value("o_destination_index", 64'(destination_index), 64'(RAZ_REGISTER));
        check_value("o_mem_srcdest_index", 64'(mem_srcdest_index), 64'(RAZ_REGISTER));
        rst_n = 1'b1;
        foreach (t_instr[i])
                run_entry(i);
        $display("Test passed");
        $finish;
end

endmodule
